// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/csr_pkg.sv
      - verilog/csr_alu.sv
      - verilog/csr_file.sv
      - verilog/csr_access_ctrl.sv
      - verilog/csr_unit.sv
  - target: simulation
    include_dirs:
      - verilog
      - dv
    files:
      - dv/tb_csr_unit.sv

// ==== dv/tb_csr_tasks.svh ====
// CSR testbench tasks and reference model
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

logic [31:0] lfsr = 32'h4ffe_60eb;           // Stimulus LFSR state
xlen_t       model_mscratch = '0;            // Expected mscratch
xlen_t       model_minstret = '0;            // Legal accesses since reset
xlen_t       mcycle_base = '0;               // Last value written to mcycle
int          cyc_budget = 8;                 // Edges allowed since mcycle_base

// Galois LFSR, one step per bit taken
function automatic xlen_t rand_bits(input int n);
  xlen_t v;
  logic  b;
  v = '0;
  for (int i = 0; i < n; i++) begin
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;           // Taps 32, 22, 2, 1
    end
    v = {v[62:0], b};
  end
  return v;
endfunction

function automatic logic is_mapped(input csr_addr_t a);
  case (a)
    `CSR_ADDR_MISA, `CSR_ADDR_MSCRATCH, `CSR_ADDR_MCYCLE, `CSR_ADDR_MINSTRET,
    `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID,
    `CSR_ADDR_MHARTID: return 1'b1;
    default:           return 1'b0;
  endcase
endfunction

// Old value of every register except mcycle, which is a range
function automatic xlen_t model_value(input csr_addr_t a);
  case (a)
    `CSR_ADDR_MISA:     return `CSR_MISA_VALUE;
    `CSR_ADDR_MSCRATCH: return model_mscratch;
    `CSR_ADDR_MINSTRET: return model_minstret;
    `CSR_ADDR_MHARTID:  return `CSR_HART_ID;
    default:            return '0;           // Vendor, arch and impl IDs
  endcase
endfunction

// One four-phase access, hold extends req after ack
task automatic run_access(input csr_op_t op_i, input csr_addr_t addr_i,
                          input xlen_t src_i, input int hold);
  logic  wi;
  logic  bad;
  xlen_t old;
  xlen_t nxt;
  int    waited;
  wi  = (op_i == CSR_OP_RW) || (src_i != '0);                 // Zero rs/rc is a read
  bad = !is_mapped(addr_i) || (wi && (addr_i[11:10] == 2'b11));
  cyc_budget += hold + 8;                    // Worst case edges of this access
  old     = model_value(addr_i);
  exp_lo  = bad ? '0 : old;
  exp_hi  = exp_lo;
  exp_err = bad;
  if (!bad && addr_i == `CSR_ADDR_MCYCLE) begin
    exp_lo = mcycle_base + 1;
    exp_hi = mcycle_base + xlen_t'(cyc_budget);
  end
  op   = op_i;
  addr = addr_i;
  src  = src_i;
  req  = 1'b1;
  waited = 0;
  while (!ack && waited < 16) begin
    @(negedge clk);
    waited++;
  end
  if (!ack) begin
    handshake_errors++;
    $display("No ack within 16 cycles for access to address %h", addr_i);
  end
  repeat (hold) @(negedge clk);              // Back-pressure on ack
  req    = 1'b0;
  waited = 0;
  while (ack && waited < 16) begin
    @(negedge clk);
    waited++;
  end
  if (ack) begin
    handshake_errors++;
    $display("ack stayed high after req dropped, address %h", addr_i);
  end
  if (!bad) begin
    case (op_i)
      CSR_OP_RW: nxt = src_i;
      CSR_OP_RS: nxt = old | src_i;
      default:   nxt = old & ~src_i;
    endcase
    if (wi && addr_i == `CSR_ADDR_MSCRATCH) model_mscratch = nxt;
    if (wi && addr_i == `CSR_ADDR_MINSTRET) model_minstret = nxt;
    if (wi && addr_i == `CSR_ADDR_MCYCLE) begin
      mcycle_base = nxt;                     // Scenario writes mcycle with rw only
      cyc_budget  = hold + 8;
    end
    model_minstret++;                        // Retire follows the write
  end
endtask

`endif

// ==== dv/tb_csr_unit.sv ====
// CSR unit testbench
`timescale 1ns/1ps

`include "csr_defines.svh"

module tb_csr_unit;

  import csr_pkg::*;

  localparam int period_ns    = 100;
  localparam int reset_cycles = 16;
  localparam int num_accesses = 33;          // Accesses in the scenario below
  localparam int max_hold     = 7;           // Hold drawn from 3 LFSR bits

  logic      clk;
  logic      rst;
  logic      req;
  csr_op_t   op;
  csr_addr_t addr;
  xlen_t     src;
  logic      ack;
  xlen_t     rdata;
  logic      err;

  int        handshake_errors = 0;
  int        rdata_errors = 0;
  int        err_errors = 0;
  xlen_t     exp_lo = '0;                    // Accepted rdata range
  xlen_t     exp_hi = '0;
  logic      exp_err = 1'b0;

  `include "tb_csr_tasks.svh"

  csr_unit dut0 (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .op    (op),
    .addr  (addr),
    .src   (src),
    .ack   (ack),
    .rdata (rdata),
    .err   (err)
  );

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Handshake rules
  ack_after_reset: assert property (@(posedge clk) rst |=> !ack)
    else begin
      handshake_errors++;
      $display("[FAIL] ack = %h after reset, expected 0", $sampled(ack));
    end
  ack_latency: assert property (@(posedge clk) disable iff (rst)
      $rose(req) |-> !ack ##1 !ack ##1 !ack ##1 ack)
    else begin
      handshake_errors++;
      $display("ack did not rise exactly three edges after req was sampled high");
    end
  ack_hold: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
    else begin
      handshake_errors++;
      $display("ack dropped while req was still high");
    end
  ack_release: assert property (@(posedge clk) disable iff (rst) (ack && !req) |=> !ack)
    else begin
      handshake_errors++;
      $display("ack did not fall on the first edge with req low");
    end
  // ack is set on the edge before it is first seen high
  ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
    else begin
      handshake_errors++;
      $display("ack rose while req was low");
    end

  // Response against the model, checked as ack rises
  rdata_check: assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> (rdata >= exp_lo) && (rdata <= exp_hi))
    else begin
      rdata_errors++;
      $display("[FAIL] rdata = %h, expected %h to %h",
               $sampled(rdata), $sampled(exp_lo), $sampled(exp_hi));
    end
  err_check: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> err == exp_err)
    else begin
      err_errors++;
      $display("[FAIL] err = %h, expected %h", $sampled(err), $sampled(exp_err));
    end

  initial begin
    #(num_accesses * (max_hold + 8) * period_ns + reset_cycles * period_ns);
    $display("Watchdog expired before the scenario finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    xlen_t v;
    int    total;
    rst  = 1'b1;
    req  = 1'b0;
    op   = CSR_OP_RW;
    addr = '0;
    src  = '0;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // Identity registers, read-set with zero operand
    run_access(CSR_OP_RS, `CSR_ADDR_MISA, '0, int'(rand_bits(3)));
    run_access(CSR_OP_RS, `CSR_ADDR_MVENDORID, '0, int'(rand_bits(3)));
    run_access(CSR_OP_RS, `CSR_ADDR_MARCHID, '0, int'(rand_bits(3)));
    run_access(CSR_OP_RS, `CSR_ADDR_MIMPID, '0, int'(rand_bits(3)));
    run_access(CSR_OP_RS, `CSR_ADDR_MHARTID, '0, int'(rand_bits(3)));
    // mscratch rw, rs, rc in turn; zero operand on 3, 7 and 11
    for (int i = 0; i < 12; i++) begin
      v = (i % 4 == 3) ? '0 : rand_bits(64);
      run_access(csr_op_t'(i % 3 + 1), `CSR_ADDR_MSCRATCH, v, int'(rand_bits(3)));
    end
    // Illegal accesses
    v = rand_bits(64);
    run_access(CSR_OP_RW, 12'h7C0, v, int'(rand_bits(3)));           // Unmapped
    v = rand_bits(64);
    run_access(CSR_OP_RS, 12'h000, v, int'(rand_bits(3)));           // Unmapped
    v = rand_bits(64);
    run_access(CSR_OP_RW, `CSR_ADDR_MVENDORID, v, int'(rand_bits(3)));
    v = rand_bits(64) | 64'd1;
    run_access(CSR_OP_RS, `CSR_ADDR_MHARTID, v, int'(rand_bits(3)));
    run_access(CSR_OP_RC, `CSR_ADDR_MARCHID, 64'd1, int'(rand_bits(3)));
    run_access(CSR_OP_RS, `CSR_ADDR_MSCRATCH, '0, int'(rand_bits(3))); // Unchanged
    run_access(CSR_OP_RS, `CSR_ADDR_MINSTRET, '0, int'(rand_bits(3))); // Not counted
    // mcycle write then bounded read
    v = rand_bits(48);
    run_access(CSR_OP_RW, `CSR_ADDR_MCYCLE, v, int'(rand_bits(3)));
    v = rand_bits(64);
    run_access(CSR_OP_RS, `CSR_ADDR_MSCRATCH, v, int'(rand_bits(3)));
    run_access(CSR_OP_RC, `CSR_ADDR_MSCRATCH, v, int'(rand_bits(3)));
    run_access(CSR_OP_RS, `CSR_ADDR_MCYCLE, '0, int'(rand_bits(3)));
    // minstret write then count
    v = rand_bits(48);
    run_access(CSR_OP_RW, `CSR_ADDR_MINSTRET, v, int'(rand_bits(3)));
    v = rand_bits(64);
    run_access(CSR_OP_RW, `CSR_ADDR_MSCRATCH, v, int'(rand_bits(3)));
    run_access(CSR_OP_RW, 12'hFFF, v, int'(rand_bits(3)));           // Illegal
    run_access(CSR_OP_RS, `CSR_ADDR_MISA, '0, int'(rand_bits(3)));
    run_access(CSR_OP_RS, `CSR_ADDR_MINSTRET, '0, int'(rand_bits(3)));
    repeat (4) @(negedge clk);
    total = handshake_errors + rdata_errors + err_errors;
    $display("Errors: handshake %0d, rdata %0d, err %0d",
             handshake_errors, rdata_errors, err_errors);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verilog
+incdir+dv
verilog/csr_pkg.sv
verilog/csr_alu.sv
verilog/csr_file.sv
verilog/csr_access_ctrl.sv
verilog/csr_unit.sv
dv/tb_csr_unit.sv

// ==== verilog/csr_access_ctrl.sv ====
// CSR access controller
`timescale 1ns/1ps

module csr_access_ctrl (
  input                      clk,
  input                      rst,
  input  logic               req,
  input  csr_pkg::csr_op_t   op,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::xlen_t     src,
  output logic               ack,
  output csr_pkg::xlen_t     rdata,
  output logic               err,
  output csr_pkg::csr_op_t   alu_op,
  output csr_pkg::xlen_t     alu_src,
  output csr_pkg::xlen_t     old_value,
  input  csr_pkg::xlen_t     new_value,
  input  logic               write_intent,
  output csr_pkg::csr_addr_t csr_idx,
  output logic               rd_en,
  output logic               wr_en,
  output logic               wr_intent,
  output csr_pkg::xlen_t     wr_data,
  input  csr_pkg::xlen_t     csr_rd_data,
  input  logic               illegal,
  output logic               retire
);

  import csr_pkg::*;

  access_state_t state;
  logic          err_q;                      // Illegal flag seen in S_READ

  // Request capture, held for the whole access
  always_ff @(posedge clk) begin
    if (state == S_IDLE && req) begin
      alu_op  <= op;
      alu_src <= src;
      csr_idx <= addr;
    end
  end

  // Old value and legality, sampled at the end of S_READ
  always_ff @(posedge clk) begin
    if (state == S_READ) begin
      old_value <= csr_rd_data;
      err_q     <= illegal;
    end
  end

  // Register file strobes
  assign rd_en     = (state == S_READ);
  assign wr_intent = (state == S_READ) & write_intent;  // Only for legality check
  assign wr_en     = (state == S_WRITE) & ~err_q & write_intent;
  assign wr_data   = new_value;

  // Handshake FSM and response registers
  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= S_IDLE;
      ack    <= 1'b0;
      err    <= 1'b0;
      rdata  <= '0;
      retire <= 1'b0;
    end else begin
      retire <= 1'b0;                        // One-cycle pulse
      case (state)
        S_IDLE: begin
          if (req) begin
            state <= S_READ;
          end
        end
        S_READ: begin
          state <= S_WRITE;
        end
        S_WRITE: begin
          state  <= S_ACK;
          ack    <= 1'b1;
          err    <= err_q;
          rdata  <= err_q ? '0 : old_value;  // No data on error
          retire <= ~err_q;                  // Legal accesses count
        end
        S_ACK: begin
          if (!req) begin                    // Four-phase release
            ack   <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== verilog/csr_alu.sv ====
// Zicsr operation logic
`timescale 1ns/1ps

module csr_alu (
  input  csr_pkg::csr_op_t op,
  input  csr_pkg::xlen_t   src,
  input  csr_pkg::xlen_t   old_value,
  output csr_pkg::xlen_t   new_value,
  output logic             write_intent
);

  import csr_pkg::*;

  logic src_nonzero;

  // rs and rc with x0 or a zero operand must not write
  assign src_nonzero = |src;

  always_comb begin
    case (op)
      CSR_OP_RW: begin
        new_value    = src;                  // Plain replace
        write_intent = 1'b1;                 // Always writes, even zero
      end
      CSR_OP_RS: begin
        new_value    = old_value | src;      // Set operand bits
        write_intent = src_nonzero;
      end
      CSR_OP_RC: begin
        new_value    = old_value & ~src;     // Clear operand bits
        write_intent = src_nonzero;
      end
      default: begin
        new_value    = old_value;            // Unused encoding, no change
        write_intent = 1'b0;
      end
    endcase
  end

endmodule

// ==== verilog/csr_defines.svh ====
// CSR unit constants
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Data and index widths, fixed by the ISA
`define CSR_XLEN   64                     // RV64 register width
`define CSR_ADDR_W 12                     // Zicsr index field

// Machine-mode CSR addresses
`define CSR_ADDR_MISA      12'h301        // ISA and extensions
`define CSR_ADDR_MSCRATCH  12'h340        // Scratch for trap handlers
`define CSR_ADDR_MCYCLE    12'hB00        // Cycle counter
`define CSR_ADDR_MINSTRET  12'hB02        // Retired access counter
`define CSR_ADDR_MVENDORID 12'hF11        // Vendor ID, read-only
`define CSR_ADDR_MARCHID   12'hF12        // Architecture ID, read-only
`define CSR_ADDR_MIMPID    12'hF13        // Implementation ID, read-only
`define CSR_ADDR_MHARTID   12'hF14        // Hart ID, read-only

// MXL = 2 in bits 63:62, only base extension I (bit 8)
`define CSR_MISA_VALUE 64'h8000_0000_0000_0100

// Single hart system
`define CSR_HART_ID 64'd0

// Identity values not implemented here read as zero
`define CSR_VENDOR_ID 64'd0
`define CSR_ARCH_ID   64'd0
`define CSR_IMP_ID    64'd0

`endif

// ==== verilog/csr_file.sv ====
// Machine-mode CSR register file
`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_file (
  input                     clk,
  input                     rst,
  input  logic              rd_en,
  input  logic              wr_en,
  input  logic              wr_intent,
  input  logic              retire,
  input  csr_pkg::csr_addr_t csr_idx,
  input  csr_pkg::xlen_t    csr_wr_data,
  output csr_pkg::xlen_t    csr_rd_data,
  output logic              illegal
);

  import csr_pkg::*;

  // Address decode
  logic sel_misa;
  logic sel_mscratch;
  logic sel_mcycle;
  logic sel_minstret;
  logic sel_mvendorid;
  logic sel_marchid;
  logic sel_mimpid;
  logic sel_mhartid;
  logic mapped;
  logic read_only;

  // Write strobes
  logic wr_mscratch;
  logic wr_mcycle;
  logic wr_minstret;

  // Implemented state
  xlen_t csr_mscratch;
  xlen_t csr_mcycle;
  xlen_t csr_minstret;
  xlen_t rd_mux;

  assign sel_misa      = (csr_idx == `CSR_ADDR_MISA);
  assign sel_mscratch  = (csr_idx == `CSR_ADDR_MSCRATCH);
  assign sel_mcycle    = (csr_idx == `CSR_ADDR_MCYCLE);
  assign sel_minstret  = (csr_idx == `CSR_ADDR_MINSTRET);
  assign sel_mvendorid = (csr_idx == `CSR_ADDR_MVENDORID);
  assign sel_marchid   = (csr_idx == `CSR_ADDR_MARCHID);
  assign sel_mimpid    = (csr_idx == `CSR_ADDR_MIMPID);
  assign sel_mhartid   = (csr_idx == `CSR_ADDR_MHARTID);

  assign mapped = sel_misa | sel_mscratch | sel_mcycle | sel_minstret
                | sel_mvendorid | sel_marchid | sel_mimpid | sel_mhartid;

  // Top two index bits 11 mark a read-only CSR
  assign read_only = &csr_idx[11:10];

  assign illegal = ~mapped | (wr_intent & read_only); // Unmapped or write to RO

  // misa is WARL with a fixed value, so writes to it are accepted and dropped
  assign wr_mscratch = wr_en & sel_mscratch;
  assign wr_mcycle   = wr_en & sel_mcycle;
  assign wr_minstret = wr_en & sel_minstret;

  // 0x340 scratch
  always_ff @(posedge clk) begin
    if (rst) begin
      csr_mscratch <= '0;
    end else if (wr_mscratch) begin
      csr_mscratch <= csr_wr_data;
    end
  end

  // 0xB00 free-running cycle counter
  always_ff @(posedge clk) begin
    if (rst) begin
      csr_mcycle <= '0;
    end else if (wr_mcycle) begin
      csr_mcycle <= csr_wr_data;                // Write wins over increment
    end else begin
      csr_mcycle <= csr_mcycle + xlen_t'(1);
    end
  end

  // 0xB02 counts completed legal accesses
  always_ff @(posedge clk) begin
    if (rst) begin
      csr_minstret <= '0;
    end else if (wr_minstret) begin
      csr_minstret <= csr_wr_data;
    end else if (retire) begin
      csr_minstret <= csr_minstret + xlen_t'(1); // Retire comes after the write
    end
  end

  // Read mux
  always_comb begin
    unique case (1'b1)
      sel_misa:      rd_mux = `CSR_MISA_VALUE;
      sel_mscratch:  rd_mux = csr_mscratch;
      sel_mcycle:    rd_mux = csr_mcycle;
      sel_minstret:  rd_mux = csr_minstret;
      sel_mvendorid: rd_mux = `CSR_VENDOR_ID;
      sel_marchid:   rd_mux = `CSR_ARCH_ID;
      sel_mimpid:    rd_mux = `CSR_IMP_ID;
      sel_mhartid:   rd_mux = `CSR_HART_ID;
      default:       rd_mux = '0;               // Unmapped index
    endcase
  end

  // Zero unless a legal read is in progress
  assign csr_rd_data = (rd_en && !illegal) ? rd_mux : '0;

endmodule

// ==== verilog/csr_pkg.sv ====
// CSR unit shared types

`include "csr_defines.svh"

package csr_pkg;

  // Register data and CSR index
  typedef logic [`CSR_XLEN-1:0]   xlen_t;     // Operand, read data, register contents
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t; // 12-bit CSR index

  // Zicsr operation, encoded as funct3[1:0]
  typedef enum logic [1:0] {
    CSR_OP_RW = 2'b01,                        // Read-write
    CSR_OP_RS = 2'b10,                        // Read-set
    CSR_OP_RC = 2'b11                         // Read-clear
  } csr_op_t;

  // Access controller states
  typedef enum logic [1:0] {
    S_IDLE  = 2'd0,                           // Wait for req
    S_READ  = 2'd1,                           // Read old value, check legality
    S_WRITE = 2'd2,                           // Commit new value
    S_ACK   = 2'd3                            // Hold ack until req drops
  } access_state_t;

endpackage

// ==== verilog/csr_unit.sv ====
// Machine-mode CSR unit top
`timescale 1ns/1ps

module csr_unit (
  input                      clk,
  input                      rst,
  input  logic               req,
  input  csr_pkg::csr_op_t   op,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::xlen_t     src,
  output logic               ack,
  output csr_pkg::xlen_t     rdata,
  output logic               err
);

  import csr_pkg::*;

  // Controller to ALU
  csr_op_t   alu_op;
  xlen_t     alu_src;
  xlen_t     old_value;
  xlen_t     new_value;
  logic      write_intent;

  // Controller to register file
  csr_addr_t csr_idx;
  logic      rd_en;
  logic      wr_en;
  logic      wr_intent;
  logic      retire;
  xlen_t     wr_data;
  xlen_t     csr_rd_data;
  logic      illegal;

  csr_access_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .op           (op),
    .addr         (addr),
    .src          (src),
    .ack          (ack),
    .rdata        (rdata),
    .err          (err),
    .alu_op       (alu_op),
    .alu_src      (alu_src),
    .old_value    (old_value),
    .new_value    (new_value),
    .write_intent (write_intent),
    .csr_idx      (csr_idx),
    .rd_en        (rd_en),
    .wr_en        (wr_en),
    .wr_intent    (wr_intent),
    .wr_data      (wr_data),
    .csr_rd_data  (csr_rd_data),
    .illegal      (illegal),
    .retire       (retire)
  );

  csr_alu u_alu (
    .op           (alu_op),
    .src          (alu_src),
    .old_value    (old_value),
    .new_value    (new_value),
    .write_intent (write_intent)
  );

  csr_file u_file (
    .clk          (clk),
    .rst          (rst),
    .rd_en        (rd_en),
    .wr_en        (wr_en),
    .wr_intent    (wr_intent),
    .retire       (retire),
    .csr_idx      (csr_idx),
    .csr_wr_data  (wr_data),
    .csr_rd_data  (csr_rd_data),
    .illegal      (illegal)
  );

endmodule
